// File: dcache.f
dcache_pkg.sv
mshr_entry.sv
mshr_alloc.sv
mshr_issue.sv
dcache_line_array.sv
dcache_ctrl.sv
dcache.sv
tb_mem_model.sv
tb_dcache.sv

// File: dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                         clock,
    input  logic                         reset,
    input  dcache_pkg::dcache_request_t  request,
    output dcache_pkg::dcache_response_t response,
    output logic                         stall,
    output dcache_pkg::mem_command_t     mem_command,
    input  dcache_pkg::mem_reply_t       mem_reply
);

    dcache_pkg::dcache_request_t access;
    dcache_pkg::line_t           line;
    logic                        hit;
    logic                        mshr_room;
    dcache_pkg::mshr_alloc_t     miss_alloc;
    dcache_pkg::mshr_alloc_t     writeback;
    dcache_pkg::mshr_alloc_t     alloc;      // whichever of the two is valid
    dcache_pkg::mshr_mask_t      load;
    dcache_pkg::mshr_mask_t      grant;
    dcache_pkg::mshr_fill_t      fill;

    dcache_pkg::mshr_status_t [dcache_pkg::n_mshr-1:0] status;
    dcache_pkg::mshr_fill_t   [dcache_pkg::n_mshr-1:0] entry_fill;

    dcache_ctrl ctrl_i (
        .clock(clock), .reset(reset), .request(request), .hit(hit), .line(line),
        .mshr_room(mshr_room), .fill(fill), .access(access), .miss_alloc(miss_alloc),
        .response(response), .stall(stall)
    );

    dcache_line_array array_i (
        .clock(clock), .reset(reset), .access(access), .fill(fill),
        .hit(hit), .line(line), .writeback(writeback)
    );

    mshr_alloc alloc_i (
        .status(status), .miss_alloc(miss_alloc), .writeback(writeback),
        .load(load), .alloc(alloc), .mshr_room(mshr_room)
    );

    for (genvar i = 0; i < dcache_pkg::n_mshr; i++) begin : g_mshr
        mshr_entry entry_i (
            .clock(clock), .reset(reset), .load(load[i]), .alloc(alloc),
            .grant(grant[i]), .mem_reply(mem_reply),
            .status(status[i]), .fill(entry_fill[i])
        );
    end

    mshr_issue issue_i (
        .status(status), .entry_fill(entry_fill), .grant(grant),
        .mem_command(mem_command), .fill(fill)
    );

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                         clock,
    input  logic                         reset,
    input  dcache_pkg::dcache_request_t  request,
    input  logic                         hit,
    input  dcache_pkg::line_t            line,
    input  logic                         mshr_room,
    input  dcache_pkg::mshr_fill_t       fill,
    output dcache_pkg::dcache_request_t  access,
    output dcache_pkg::mshr_alloc_t      miss_alloc,
    output dcache_pkg::dcache_response_t response,
    output logic                         stall
);

    dcache_pkg::dc_state_t       state, state_next;
    dcache_pkg::dcache_request_t held;       // the request that missed
    logic                        miss;
    logic                        resp_valid;

    // zero-extended load data, little-endian in the line
    function automatic dcache_pkg::word_t extract(
        input dcache_pkg::line_t           l,
        input dcache_pkg::dcache_request_t req
    );
        logic [dcache_pkg::offset_w-1:0] off;
        off = req.addr[dcache_pkg::offset_w-1:0];
        case (req.size)
            dcache_pkg::size_byte: return {24'b0, l[{off, 3'b000} +: 8]};
            dcache_pkg::size_half: return {16'b0, l[{off[2:1], 4'b0000} +: 16]};
            default:               return l[{off[2], 5'b00000} +: 32];
        endcase
    endfunction

    assign access = (state == dcache_pkg::st_ready) ? request : held;
    assign miss   = request.valid && !hit;
    assign stall  = (state != dcache_pkg::st_ready);

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::st_ready:
                if (miss) state_next = mshr_room ? dcache_pkg::st_wait_fill : dcache_pkg::st_wait_mshr;
            dcache_pkg::st_wait_mshr:
                if (mshr_room) state_next = dcache_pkg::st_wait_fill;
            dcache_pkg::st_wait_fill:
                if (fill.valid) state_next = dcache_pkg::st_ready;
            default: state_next = dcache_pkg::st_ready;
        endcase
    end

    // the line read goes out on the edge into wait_fill
    always_comb begin
        miss_alloc       = '0;
        miss_alloc.valid = (state_next == dcache_pkg::st_wait_fill) && (state != dcache_pkg::st_wait_fill);
        miss_alloc.op    = dcache_pkg::mem_read;
        miss_alloc.addr  = {access.addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w],
                            {dcache_pkg::offset_w{1'b0}}};
    end

    assign resp_valid = (state == dcache_pkg::st_ready && request.valid && hit)
                     || (state == dcache_pkg::st_wait_fill && fill.valid);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= dcache_pkg::st_ready;
            response <= '0;
        end else begin
            state              <= state_next;
            response.valid     <= resp_valid;
            response.read_data <= extract(line, access);
        end
    end

    always_ff @(posedge clock) begin
        if (state == dcache_pkg::st_ready && miss) held <= request;   // pipeline may move on
    end

    // only the miss read produces a fill, and it is issued after leaving ready
    no_fill_in_ready: assert property (@(posedge clock) disable iff (reset)
        state == dcache_pkg::st_ready |-> !fill.valid)
        else $error("dcache_ctrl: fill arrived while ready");

endmodule

// File: dcache_line_array.sv
`timescale 1ns/1ps

module dcache_line_array (
    input  logic                        clock,
    input  logic                        reset,
    input  dcache_pkg::dcache_request_t access,
    input  dcache_pkg::mshr_fill_t      fill,
    output logic                        hit,
    output dcache_pkg::line_t           line,
    output dcache_pkg::mshr_alloc_t     writeback
);

    dcache_pkg::cache_tag_t tags  [dcache_pkg::n_lines];
    dcache_pkg::line_t      lines [dcache_pkg::n_lines];
    logic [dcache_pkg::n_lines-1:0] valid_q;
    logic [dcache_pkg::n_lines-1:0] dirty_q;

    dcache_pkg::line_index_t idx;
    dcache_pkg::line_index_t fill_idx;
    dcache_pkg::cache_tag_t  access_tag;
    logic                    is_store;
    logic                    store_hit;
    dcache_pkg::line_t       hit_merged;
    dcache_pkg::line_t       fill_merged;

    function automatic dcache_pkg::line_t merge_store(
        input dcache_pkg::line_t           base,
        input dcache_pkg::dcache_request_t req
    );
        dcache_pkg::line_t               merged;
        logic [dcache_pkg::offset_w-1:0] off;
        merged = base;
        off    = req.addr[dcache_pkg::offset_w-1:0];
        case (req.size)
            dcache_pkg::size_byte: merged[{off, 3'b000} +: 8]       = req.write_data[7:0];
            dcache_pkg::size_half: merged[{off[2:1], 4'b0000} +: 16] = req.write_data[15:0];
            default:               merged[{off[2], 5'b00000} +: 32]  = req.write_data;
        endcase
        return merged;
    endfunction

    assign idx        = access.addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
    assign access_tag = access.addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
    assign fill_idx   = fill.addr[dcache_pkg::offset_w +: dcache_pkg::index_w];

    assign hit       = access.valid && valid_q[idx] && (tags[idx] == access_tag);
    assign is_store  = access.valid && (access.op == dcache_pkg::mem_write);
    assign store_hit = is_store && hit;

    assign hit_merged  = merge_store(lines[idx], access);
    assign fill_merged = is_store ? merge_store(fill.data, access) : fill.data;

    // on a fill the raw memory line feeds the response
    assign line = fill.valid ? fill.data : lines[idx];

    // dirty victim goes back to memory in the fill cycle
    always_comb begin
        writeback       = '0;
        writeback.valid = fill.valid && valid_q[fill_idx] && dirty_q[fill_idx];
        writeback.op    = dcache_pkg::mem_write;
        writeback.addr  = {tags[fill_idx], fill_idx, {dcache_pkg::offset_w{1'b0}}};
        writeback.data  = lines[fill_idx];
    end

    always_ff @(posedge clock) begin
        if (fill.valid) begin
            tags[fill_idx]  <= fill.addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
            lines[fill_idx] <= fill_merged;
        end else if (store_hit) begin
            lines[idx] <= hit_merged;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill.valid) begin
            valid_q[fill_idx] <= 1'b1;
            dirty_q[fill_idx] <= is_store;     // store miss leaves the line dirty
        end else if (store_hit) begin
            dirty_q[idx] <= 1'b1;
        end
    end

endmodule

// File: dcache_pkg.sv
package dcache_pkg;

    localparam int addr_w     = 32;
    localparam int line_bytes = 8;
    localparam int n_lines    = 32;
    localparam int n_mshr     = 4;
    localparam int mem_tag_w  = 4;
    localparam int word_w     = 32;
    localparam int offset_w   = $clog2(line_bytes);       // byte within a line
    localparam int index_w    = $clog2(n_lines);
    localparam int tag_w      = addr_w - index_w - offset_w;

    typedef logic [addr_w-1:0]       addr_t;
    typedef logic [line_bytes*8-1:0] line_t;
    typedef logic [word_w-1:0]       word_t;
    typedef logic [tag_w-1:0]        cache_tag_t;
    typedef logic [index_w-1:0]      line_index_t;
    typedef logic [mem_tag_w-1:0]    mem_tag_t;         // zero means no tag
    typedef logic [n_mshr-1:0]       mshr_mask_t;

    typedef enum logic [1:0] {mem_read = 2'd0, mem_write = 2'd1} mem_op_t;
    typedef enum logic [1:0] {size_byte = 2'd0, size_half = 2'd1, size_word = 2'd2} mem_size_t;
    typedef enum logic [1:0] {bus_none = 2'd0, bus_load = 2'd1, bus_store = 2'd2} bus_command_t;
    typedef enum logic [1:0] {st_ready, st_wait_mshr, st_wait_fill} dc_state_t;

    typedef struct packed {
        logic valid; mem_op_t op; mem_size_t size; addr_t addr; word_t write_data;
    } dcache_request_t;

    typedef struct packed {logic valid; word_t read_data;} dcache_response_t;

    typedef struct packed {bus_command_t command; addr_t addr; line_t data;} mem_command_t;

    typedef struct packed {mem_tag_t accept_tag; line_t data; mem_tag_t tag;} mem_reply_t;

    // one request for a free mshr slot, addr is line aligned
    typedef struct packed {logic valid; mem_op_t op; addr_t addr; line_t data;} mshr_alloc_t;

    typedef struct packed {
        logic valid; logic issued; mem_op_t op; addr_t addr; line_t data;
    } mshr_status_t;

    typedef struct packed {logic valid; addr_t addr; line_t data;} mshr_fill_t;

endpackage

// File: dcache_testdata.txt
# op size addr wdata expected test (all hex except test)
# op 0 load, 1 store, 2 wait for a memory store of the line at addr; size 0 byte, 1 half, 2 word
0 2 00001000 00000000 5a5a1000 2
0 2 00001000 00000000 5a5a1000 2
0 2 00001004 00000000 5a5a1004 2
1 0 00001001 000000ab 00000000 3
0 2 00001000 00000000 5a5aab00 3
0 0 00001001 00000000 000000ab 3
0 1 00001002 00000000 00005a5a 3
1 1 00001006 0000c0de 00000000 3
0 2 00001004 00000000 c0de1004 3
1 2 00002010 12345678 00000000 3
0 2 00002010 00000000 12345678 3
1 0 00003023 000000ee 00000000 3
0 2 00003020 00000000 ee5a3020 3
0 0 00003023 00000000 000000ee 3
0 2 00001100 00000000 5a5a1100 4
2 0 00001000 00000000 00000000 4
0 2 00001000 00000000 5a5aab00 4
0 2 00001004 00000000 c0de1004 4
0 2 00002210 00000000 5a5a2210 4
2 0 00002010 00000000 00000000 4
0 2 00002010 00000000 12345678 4
1 2 00004008 deadbeef 00000000 5
0 2 00004108 00000000 5a5a4108 5
0 2 00004008 00000000 deadbeef 5
0 0 0000400b 00000000 000000de 5
0 1 0000400c 00000000 0000400c 5
0 2 00003124 00000000 5a5a3124 5
0 2 00003020 00000000 ee5a3020 5

// File: mshr_alloc.sv
`timescale 1ns/1ps

module mshr_alloc (
    input  dcache_pkg::mshr_status_t [dcache_pkg::n_mshr-1:0] status,
    input  dcache_pkg::mshr_alloc_t                           miss_alloc,
    input  dcache_pkg::mshr_alloc_t                           writeback,
    output dcache_pkg::mshr_mask_t                            load,
    output dcache_pkg::mshr_alloc_t                           alloc,
    output logic                                              mshr_room
);

    dcache_pkg::mshr_mask_t              free;
    dcache_pkg::mshr_mask_t              first_free;
    logic [$clog2(dcache_pkg::n_mshr):0] n_free;

    always_comb begin
        free   = '0;
        n_free = '0;
        for (int i = 0; i < dcache_pkg::n_mshr; i++) begin
            free[i] = !status[i].valid;
            if (free[i]) begin
                n_free = n_free + 1'b1;
            end
        end
    end

    assign first_free = free & (~free + 1'b1);   // lowest free slot
    assign alloc      = miss_alloc.valid ? miss_alloc : writeback;
    assign load       = alloc.valid ? first_free : '0;

    // keep one slot back for the write-back that may follow the fill
    assign mshr_room = (n_free >= 2);

    always_comb begin
        if (alloc.valid) begin
            assert #0 (free != '0)
                else $error("mshr_alloc: allocation with no free entry");
        end
    end

endmodule

// File: mshr_entry.sv
`timescale 1ns/1ps

module mshr_entry (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     load,
    input  dcache_pkg::mshr_alloc_t  alloc,
    input  logic                     grant,
    input  dcache_pkg::mem_reply_t   mem_reply,
    output dcache_pkg::mshr_status_t status,
    output dcache_pkg::mshr_fill_t   fill
);

    logic                  valid_q;
    logic                  issued_q;
    dcache_pkg::mem_op_t   op_q;
    dcache_pkg::addr_t     addr_q;
    dcache_pkg::line_t     data_q;
    dcache_pkg::mem_tag_t  tag_q;       // tag memory gave on acceptance
    logic                  accepted;
    logic                  replied;

    assign accepted = grant && (mem_reply.accept_tag != '0);
    assign replied  = valid_q && issued_q && (op_q == dcache_pkg::mem_read)
                   && (mem_reply.tag != '0) && (mem_reply.tag == tag_q);

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q  <= 1'b0;
            issued_q <= 1'b0;
        end else if (load) begin
            valid_q  <= 1'b1;
            issued_q <= 1'b0;
        end else if (accepted) begin
            valid_q  <= (op_q != dcache_pkg::mem_write);    // stores are done here
            issued_q <= 1'b1;
        end else if (replied) begin
            valid_q  <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            op_q   <= alloc.op;
            addr_q <= alloc.addr;
            data_q <= alloc.data;
        end
        if (accepted) tag_q <= mem_reply.accept_tag;
    end

    assign status = '{valid: valid_q, issued: issued_q, op: op_q, addr: addr_q, data: data_q};

    // zero when idle so the issue block can OR the fills
    assign fill.valid = replied;
    assign fill.addr  = replied ? addr_q : '0;
    assign fill.data  = replied ? mem_reply.data : '0;

endmodule

// File: mshr_issue.sv
`timescale 1ns/1ps

module mshr_issue (
    input  dcache_pkg::mshr_status_t [dcache_pkg::n_mshr-1:0] status,
    input  dcache_pkg::mshr_fill_t   [dcache_pkg::n_mshr-1:0] entry_fill,
    output dcache_pkg::mshr_mask_t                            grant,
    output dcache_pkg::mem_command_t                          mem_command,
    output dcache_pkg::mshr_fill_t                            fill
);

    dcache_pkg::mshr_mask_t want_write;
    dcache_pkg::mshr_mask_t want_read;
    dcache_pkg::mshr_mask_t fill_valid;

    always_comb begin
        want_write = '0;
        want_read  = '0;
        for (int i = 0; i < dcache_pkg::n_mshr; i++) begin
            if (status[i].valid && !status[i].issued) begin
                want_write[i] = (status[i].op == dcache_pkg::mem_write);
                want_read[i]  = (status[i].op == dcache_pkg::mem_read);
            end
        end
    end

    // write-backs first so a later read sees the stored line
    assign grant = (want_write != '0) ? (want_write & (~want_write + 1'b1))
                                      : (want_read & (~want_read + 1'b1));

    always_comb begin
        mem_command = '{command: dcache_pkg::bus_none, addr: '0, data: '0};
        fill        = '0;
        for (int i = 0; i < dcache_pkg::n_mshr; i++) begin
            if (grant[i]) begin
                mem_command.command = (status[i].op == dcache_pkg::mem_write) ?
                                      dcache_pkg::bus_store : dcache_pkg::bus_load;
                mem_command.addr    = status[i].addr;
                mem_command.data    = status[i].data;
            end
            fill          = fill | entry_fill[i];
            fill_valid[i] = entry_fill[i].valid;
        end
    end

    always_comb begin
        if (!$isunknown(fill_valid)) begin
            assert #0 ($onehot0(fill_valid))
                else $error("mshr_issue: more than one fill valid");
        end
    end

endmodule

// File: run_dcache.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f dcache.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_dcache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int max_wait = 200;      // cycles allowed for any single wait

    logic                         clock;
    logic                         reset;
    dcache_pkg::dcache_request_t  request;
    dcache_pkg::dcache_response_t response;
    logic                         stall;
    dcache_pkg::mem_command_t     mem_command;
    dcache_pkg::mem_reply_t       mem_reply;
    dcache_pkg::addr_t            last_store_addr;

    int   errors;
    int   checks;
    int   tests;
    int   test_errors;
    int   test_checks;
    int   current_test;
    logic aborted;

    dcache dcache_i (
        .clock(clock), .reset(reset), .request(request), .response(response),
        .stall(stall), .mem_command(mem_command), .mem_reply(mem_reply)
    );

    tb_mem_model mem_i (
        .clock(clock), .reset(reset), .command(mem_command), .reply(mem_reply),
        .last_store_addr(last_store_addr)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        test_checks++;
        assert (actual === expected)
            else begin
                $display("[FAIL] test %0d: %s is %h, expected %h", current_test, name,
                         actual, expected);
                errors++;
                test_errors++;
            end
    endtask

    task automatic finish_test();
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", current_test,
                 (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic give_up(input string why);
        $display("timeout in test %0d: %s", current_test, why);
        errors++;
        test_errors++;
        aborted = 1'b1;
    endtask

    // idle outputs and no memory command for a few cycles
    task automatic check_idle_after_reset();
        repeat (4) begin
            check_value("stall", {31'b0, stall}, 32'h0);
            check_value("response.valid", {31'b0, response.valid}, 32'h0);
            check_value("mem_command.command", {30'b0, mem_command.command}, 32'h0);
            @(negedge clock);
        end
    endtask

    // one pipeline access that returns at the negedge of the response cycle
    task automatic run_access(input int op, input int size, input dcache_pkg::addr_t addr,
                              input dcache_pkg::word_t wdata, input dcache_pkg::word_t expected);
        int waited;
        waited = 0;
        while (stall && waited < max_wait) begin
            @(negedge clock);
            waited++;
        end
        if (stall) begin
            give_up($sformatf("stall stayed high before the access to %h", addr));
            return;
        end
        @(posedge clock);
        request <= '{valid: 1'b1, op: dcache_pkg::mem_op_t'(op[1:0]),
                     size: dcache_pkg::mem_size_t'(size[1:0]), addr: addr, write_data: wdata};
        @(posedge clock);
        request <= '0;                  // cache holds a missing request itself
        waited = 0;
        @(negedge clock);
        while (!response.valid && waited < max_wait) begin
            @(negedge clock);
            waited++;
        end
        if (!response.valid) begin
            give_up($sformatf("no response to the access to %h", addr));
        end else begin
            check_value("stall", {31'b0, stall}, 32'h0);
            if (op == 0) begin
                check_value("read_data", response.read_data, expected);
            end
        end
    endtask

    // the evicted dirty line has to show up as a store in the memory model
    task automatic expect_store(input dcache_pkg::addr_t addr);
        int waited;
        waited = 0;
        while (last_store_addr !== addr && waited < max_wait) begin
            @(negedge clock);
            waited++;
        end
        check_value("last_store_addr", last_store_addr, addr);
    endtask

    initial begin
        string       text;
        int          fd;
        int          fields;
        int          op;
        int          size;
        int          num;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        reset        = 1'b1;
        request      = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        test_errors  = 0;
        test_checks  = 0;
        aborted      = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        current_test = 1;
        check_idle_after_reset();
        finish_test();
        current_test = 0;
        fd = $fopen("dcache_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open dcache_testdata.txt");
            errors++;
            aborted = 1'b1;
        end
        while (!aborted && $fgets(text, fd) > 0) begin
            if (text.len() < 2 || text.substr(0, 0) == "#") continue;
            fields = $sscanf(text, "%h %h %h %h %h %d", op, size, addr, wdata, expected, num);
            if (fields != 6) begin
                $display("unreadable testdata line: %s", text);
                errors++;
                aborted = 1'b1;
            end else begin
                if (num != current_test) begin
                    if (current_test != 0) finish_test();
                    current_test = num;
                end
                if (op == 2) begin
                    expect_store(addr);
                end else begin
                    run_access(op, size, addr, wdata, expected);
                end
            end
        end
        if (current_test != 0) finish_test();
        if (fd != 0) $fclose(fd);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::mem_command_t command,
    output dcache_pkg::mem_reply_t   reply,
    output dcache_pkg::addr_t        last_store_addr
);

    integer               seed = 32'h2c0865ca;
    dcache_pkg::word_t    words [dcache_pkg::addr_t];   // written words only
    logic                 refuse;                       // redrawn every cycle
    dcache_pkg::mem_tag_t next_tag;
    dcache_pkg::mem_tag_t accept_tag;
    dcache_pkg::mem_tag_t reply_tag;
    dcache_pkg::line_t    reply_data;
    logic [15:0]          pending;                      // one bit per tag
    dcache_pkg::line_t    pend_data  [16];
    int                   pend_delay [16];

    // untouched words follow the address rule
    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t a);
        if (words.exists(a)) begin
            return words[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    assign accept_tag = (command.command != dcache_pkg::bus_none && !refuse) ? next_tag : '0;
    assign reply      = '{accept_tag: accept_tag, data: reply_data, tag: reply_tag};

    always @(posedge clock) begin
        logic answered;
        answered = 1'b0;
        if (reset) begin
            refuse          <= 1'b0;
            next_tag        <= 4'd1;
            pending         <= '0;
            reply_tag       <= '0;
            reply_data      <= '0;
            last_store_addr <= '0;
        end else begin
            refuse     <= ($random(seed) & 3) == 0;
            reply_tag  <= '0;
            reply_data <= '0;
            // at most one load answer per cycle
            for (int t = 1; t < 16; t++) begin
                if (pending[t] && pend_delay[t] <= 1 && !answered) begin
                    reply_tag  <= dcache_pkg::mem_tag_t'(t);
                    reply_data <= pend_data[t];
                    pending[t] <= 1'b0;
                    answered    = 1'b1;
                end else if (pending[t] && pend_delay[t] > 1) begin
                    pend_delay[t] <= pend_delay[t] - 1;
                end
            end
            if (accept_tag != '0) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;   // zero is never used
                if (command.command == dcache_pkg::bus_store) begin
                    words[command.addr]     = command.data[31:0];
                    words[command.addr + 4] = command.data[63:32];
                    last_store_addr <= command.addr;
                end else begin
                    pending[accept_tag]    <= 1'b1;
                    pend_data[accept_tag]  <= {read_word(command.addr + 4),
                                               read_word(command.addr)};
                    pend_delay[accept_tag] <= 1 + int'($unsigned($random(seed)) % 6);
                end
            end
        end
    end

endmodule
